/* design/dadda_mul_consts.svh */
`ifndef DADDA_MUL_CONSTS_SVH
`define DADDA_MUL_CONSTS_SVH

// datapath widths
`define MUL_WIDTH       16
`define PROD_WIDTH      32

// wishbone register file
`define WB_ADR_WIDTH    3
`define WB_DAT_WIDTH    32

// control and status bit positions
`define CTRL_START_BIT  0
`define STATUS_BUSY_BIT 0
`define STATUS_DONE_BIT 1

`endif

/* design/dadda_mul_pkg.sv */
`include "dadda_mul_consts.svh"

package dadda_mul_pkg;

        typedef logic [`MUL_WIDTH-1:0]  operand_t;
        typedef logic [`PROD_WIDTH-1:0] product_t;

        // two rows left after the dadda reduction
        typedef struct packed {
                product_t sum_row;
                product_t carry_row;
                logic     valid;
        } cs_rows_t;

        typedef struct packed {
                operand_t a;
                operand_t b;
                logic     valid;
        } op_pair_t;

        typedef struct packed {
                product_t prod;
                logic     valid;
        } prod_res_t;

        typedef struct packed {
                logic                     cyc;
                logic                     stb;
                logic                     we;
                logic [`WB_ADR_WIDTH-1:0] adr;
                logic [`WB_DAT_WIDTH-1:0] dat;
        } wb_req_t;

        typedef struct packed {
                logic                     ack;
                logic [`WB_DAT_WIDTH-1:0] dat;
        } wb_rsp_t;

        typedef enum logic [`WB_ADR_WIDTH-1:0] {
                REG_A      = 3'd0,
                REG_B      = 3'd1,
                REG_CTRL   = 3'd2,
                REG_STATUS = 3'd3,
                REG_RESULT = 3'd4
        } reg_addr_e;

        typedef enum logic [1:0] {
                IDLE,
                REDUCE,
                SUM,
                DONE
        } mul_state_e;

endpackage

/* design/wb_mul_ctrl.sv */
`timescale 1ns/1ps
`include "dadda_mul_consts.svh"

module wb_mul_ctrl (
        input  logic                     clk,
        input  logic                     rst_n,
        input  dadda_mul_pkg::wb_req_t   wb_in,
        output dadda_mul_pkg::wb_rsp_t   wb_out,
        output dadda_mul_pkg::op_pair_t  ops,
        input  dadda_mul_pkg::prod_res_t prod
);

        dadda_mul_pkg::mul_state_e state;
        dadda_mul_pkg::mul_state_e state_nxt;
        dadda_mul_pkg::operand_t   a_q;
        dadda_mul_pkg::operand_t   b_q;
        dadda_mul_pkg::product_t   result_q;
        logic                      ack_q;
        logic                      done_q;
        logic                      start_q;
        logic                      req;
        logic                      busy;
        logic                      start;
        logic [`WB_DAT_WIDTH-1:0]  rd_dat;

        // a new request is taken only when no ack is pending
        assign req  = wb_in.cyc & wb_in.stb & ~ack_q;
        assign busy = (state == dadda_mul_pkg::REDUCE) || (state == dadda_mul_pkg::SUM);

        assign start = req & wb_in.we & ~busy &
                       (wb_in.adr == dadda_mul_pkg::REG_CTRL) &
                       wb_in.dat[`CTRL_START_BIT];

        always_comb begin
                state_nxt = state;
                case (state)
                        dadda_mul_pkg::IDLE: begin
                                if (start)
                                        state_nxt = dadda_mul_pkg::REDUCE;
                        end
                        dadda_mul_pkg::REDUCE: state_nxt = dadda_mul_pkg::SUM;
                        dadda_mul_pkg::SUM: begin
                                if (prod.valid)
                                        state_nxt = dadda_mul_pkg::DONE;
                        end
                        // a start right after completion skips idle
                        dadda_mul_pkg::DONE: begin
                                state_nxt = start ? dadda_mul_pkg::REDUCE : dadda_mul_pkg::IDLE;
                        end
                        default: state_nxt = dadda_mul_pkg::IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state    <= dadda_mul_pkg::IDLE;
                        ack_q    <= 1'b0;
                        done_q   <= 1'b0;
                        start_q  <= 1'b0;
                        a_q      <= '0;
                        b_q      <= '0;
                        result_q <= '0;
                end else begin
                        state   <= state_nxt;
                        ack_q   <= req;
                        start_q <= start;
                        if (req && wb_in.we) begin
                                case (dadda_mul_pkg::reg_addr_e'(wb_in.adr))
                                        dadda_mul_pkg::REG_A: a_q <= wb_in.dat[`MUL_WIDTH-1:0];
                                        dadda_mul_pkg::REG_B: b_q <= wb_in.dat[`MUL_WIDTH-1:0];
                                        default: ;
                                endcase
                        end
                        if (prod.valid)
                                result_q <= prod.prod;
                        // done lives until the next accepted start
                        if (start)
                                done_q <= 1'b0;
                        else if (prod.valid)
                                done_q <= 1'b1;
                end
        end

        // read mux, address is still held while ack is up
        always_comb begin
                rd_dat = '0;
                case (dadda_mul_pkg::reg_addr_e'(wb_in.adr))
                        dadda_mul_pkg::REG_A:      rd_dat[`MUL_WIDTH-1:0] = a_q;
                        dadda_mul_pkg::REG_B:      rd_dat[`MUL_WIDTH-1:0] = b_q;
                        dadda_mul_pkg::REG_STATUS: begin
                                rd_dat[`STATUS_BUSY_BIT] = busy;
                                rd_dat[`STATUS_DONE_BIT] = done_q;
                        end
                        dadda_mul_pkg::REG_RESULT: rd_dat[`PROD_WIDTH-1:0] = result_q;
                        default:                   rd_dat = '0;
                endcase
        end

        assign wb_out.ack = ack_q;
        assign wb_out.dat = rd_dat;

        assign ops.a     = a_q;
        assign ops.b     = b_q;
        assign ops.valid = start_q;

endmodule

/* design/dadda_tree.sv */
`timescale 1ns/1ps
`include "dadda_mul_consts.svh"

module dadda_tree (
        input  logic                    clk,
        input  logic                    rst_n,
        input  dadda_mul_pkg::op_pair_t ops,
        output dadda_mul_pkg::cs_rows_t rows
);

        localparam int MW     = `MUL_WIDTH;
        localparam int PW     = `PROD_WIDTH;
        localparam int MAX_H  = `MUL_WIDTH;
        localparam int MAX_FA = MAX_H / 3;
        localparam int STAGES = 6;
        // dadda height sequence for a 16 bit tree
        localparam int TARGET [STAGES] = '{13, 9, 6, 4, 3, 2};

        logic                    col [PW][MAX_H];
        logic                    nxt [PW][MAX_H];
        int                      h   [PW];
        int                      nh  [PW];
        dadda_mul_pkg::product_t sum_row;
        dadda_mul_pkg::product_t carry_row;
        dadda_mul_pkg::product_t sum_q;
        dadda_mul_pkg::product_t carry_q;
        logic                    valid_q;

        always_comb begin : reduce
                int cin;
                int ex;
                int nfa;
                int nha;
                int k;
                for (int c = 0; c < PW; c++) begin
                        h[c] = 0;
                        for (int r = 0; r < MAX_H; r++) begin
                                col[c][r] = 1'b0;
                        end
                end
                // and array, a[i] & b[j] has weight i+j
                for (int i = 0; i < MW; i++) begin
                        for (int j = 0; j < MW; j++) begin
                                col[i + j][h[i + j]] = ops.a[i] & ops.b[j];
                                h[i + j] = h[i + j] + 1;
                        end
                end
                for (int s = 0; s < STAGES; s++) begin
                        for (int c = 0; c < PW; c++) begin
                                nh[c] = 0;
                                for (int r = 0; r < MAX_H; r++) begin
                                        nxt[c][r] = 1'b0;
                                end
                        end
                        cin = 0;
                        for (int c = 0; c < PW; c++) begin
                                // carries from column c-1 count toward this height
                                ex  = h[c] + cin - TARGET[s];
                                nfa = 0;
                                nha = 0;
                                if (ex > 0) begin
                                        nfa = ex / 2;
                                        nha = ex % 2;
                                end
                                k = 0;
                                for (int f = 0; f < MAX_FA; f++) begin
                                        if (f < nfa) begin
                                                nxt[c][nh[c]] = col[c][k] ^ col[c][k + 1] ^
                                                                col[c][k + 2];
                                                nh[c] = nh[c] + 1;
                                                if (c < PW - 1) begin
                                                        nxt[c + 1][nh[c + 1]] =
                                                                (col[c][k] & col[c][k + 1]) |
                                                                (col[c][k + 2] &
                                                                 (col[c][k] ^ col[c][k + 1]));
                                                        nh[c + 1] = nh[c + 1] + 1;
                                                end
                                                k = k + 3;
                                        end
                                end
                                if (nha > 0) begin
                                        nxt[c][nh[c]] = col[c][k] ^ col[c][k + 1];
                                        nh[c] = nh[c] + 1;
                                        if (c < PW - 1) begin
                                                nxt[c + 1][nh[c + 1]] = col[c][k] & col[c][k + 1];
                                                nh[c + 1] = nh[c + 1] + 1;
                                        end
                                        k = k + 2;
                                end
                                // untouched bits drop straight through
                                for (int r = 0; r < MAX_H; r++) begin
                                        if (r >= k && r < h[c]) begin
                                                nxt[c][nh[c]] = col[c][r];
                                                nh[c] = nh[c] + 1;
                                        end
                                end
                                cin = nfa + nha;
                        end
                        for (int c = 0; c < PW; c++) begin
                                h[c] = nh[c];
                                for (int r = 0; r < MAX_H; r++) begin
                                        col[c][r] = nxt[c][r];
                                end
                        end
                end
                for (int c = 0; c < PW; c++) begin
                        sum_row[c]   = col[c][0];
                        carry_row[c] = col[c][1];
                end
        end

        always_ff @(posedge clk) begin
                sum_q   <= sum_row;
                carry_q <= carry_row;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        valid_q <= 1'b0;
                else
                        valid_q <= ops.valid;
        end

        assign rows.sum_row   = sum_q;
        assign rows.carry_row = carry_q;
        assign rows.valid     = valid_q;

endmodule

/* design/cp_adder.sv */
`timescale 1ns/1ps
`include "dadda_mul_consts.svh"

module cp_adder (
        input  logic                     clk,
        input  logic                     rst_n,
        input  dadda_mul_pkg::cs_rows_t  rows,
        output dadda_mul_pkg::prod_res_t prod
);

        localparam int PW     = `PROD_WIDTH;
        localparam int LEVELS = $clog2(PW);

        logic [PW-1:0]           g [LEVELS + 1];
        logic [PW-1:0]           p [LEVELS + 1];
        dadda_mul_pkg::product_t sum;
        dadda_mul_pkg::product_t sum_q;
        logic                    valid_q;

        assign g[0] = rows.sum_row & rows.carry_row;
        assign p[0] = rows.sum_row ^ rows.carry_row;

        // kogge-stone prefix, span doubles each level
        for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_lvl
                localparam int DIST = 1 << lvl;
                for (genvar i = 0; i < PW; i++) begin : g_bit
                        if (i >= DIST) begin : g_merge
                                assign g[lvl + 1][i] = g[lvl][i] | (p[lvl][i] & g[lvl][i - DIST]);
                                assign p[lvl + 1][i] = p[lvl][i] & p[lvl][i - DIST];
                        end else begin : g_pass
                                assign g[lvl + 1][i] = g[lvl][i];
                                assign p[lvl + 1][i] = p[lvl][i];
                        end
                end
        end

        // no carry in, so bit 0 is the plain half sum
        assign sum = p[0] ^ {g[LEVELS][PW-2:0], 1'b0};

        always_ff @(posedge clk) begin
                sum_q <= sum;
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        valid_q <= 1'b0;
                else
                        valid_q <= rows.valid;
        end

        assign prod.prod  = sum_q;
        assign prod.valid = valid_q;

endmodule

/* design/dadda_mul_top.sv */
`timescale 1ns/1ps

module dadda_mul_top (
        input  logic                   clk,
        input  logic                   rst_n,
        input  dadda_mul_pkg::wb_req_t wb_in,
        output dadda_mul_pkg::wb_rsp_t wb_out
);

        dadda_mul_pkg::op_pair_t  ops;
        dadda_mul_pkg::cs_rows_t  rows;
        dadda_mul_pkg::prod_res_t prod;

        wb_mul_ctrl u_ctrl (
                .clk    (clk),
                .rst_n  (rst_n),
                .wb_in  (wb_in),
                .wb_out (wb_out),
                .ops    (ops),
                .prod   (prod)
        );

        // stage one, and array and reduction
        dadda_tree u_tree (
                .clk   (clk),
                .rst_n (rst_n),
                .ops   (ops),
                .rows  (rows)
        );

        // stage two, final add
        cp_adder u_add (
                .clk   (clk),
                .rst_n (rst_n),
                .rows  (rows),
                .prod  (prod)
        );

endmodule

/* tb/wb_master_tasks.svh */
`ifndef WB_MASTER_TASKS_SVH
`define WB_MASTER_TASKS_SVH

// one classic cycle, request held until ack comes back
task automatic bus_cycle(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
                         input logic [`WB_DAT_WIDTH-1:0] wdat,
                         output logic [`WB_DAT_WIDTH-1:0] rdat);
        int waited;
        waited    = 0;
        wb_in.cyc = 1'b1;
        wb_in.stb = 1'b1;
        wb_in.we  = we;
        wb_in.adr = adr;
        wb_in.dat = wdat;
        @(posedge clk);
        #1;
        while (!wb_out.ack && waited < 16) begin
                @(posedge clk);
                #1;
                waited++;
        end
        if (!wb_out.ack) begin
                errors++;
                $display("no ack came back for the access to address %0d", adr);
        end
        rdat = wb_out.dat;
        wb_in = '0;
        accesses++;
endtask

task automatic wb_write(input logic [`WB_ADR_WIDTH-1:0] adr,
                        input logic [`WB_DAT_WIDTH-1:0] wdat);
        logic [`WB_DAT_WIDTH-1:0] unused;
        bus_cycle(1'b1, adr, wdat, unused);
endtask

task automatic wb_read(input logic [`WB_ADR_WIDTH-1:0] adr,
                       output logic [`WB_DAT_WIDTH-1:0] rdat);
        bus_cycle(1'b0, adr, '0, rdat);
endtask

task automatic check_product(input string name, input dadda_mul_pkg::product_t got,
                             input dadda_mul_pkg::product_t exp);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

task automatic check_data(input string name, input logic [`WB_DAT_WIDTH-1:0] got,
                          input logic [`WB_DAT_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

task automatic check_status(input logic [`WB_DAT_WIDTH-1:0] got, input logic busy,
                            input logic done);
        check_data("status.busy", got[`STATUS_BUSY_BIT], busy);
        check_data("status.done", got[`STATUS_DONE_BIT], done);
endtask

`endif

/* tb/dadda_mul_tb.sv */
`timescale 1ns/1ps
`include "dadda_mul_consts.svh"

module dadda_mul_tb;

        localparam int CYCLE_LIMIT = 4000;
        localparam logic [`WB_DAT_WIDTH-1:0] START = 32'h1 << `CTRL_START_BIT;

        logic                   clk;
        logic                   rst_n;
        dadda_mul_pkg::wb_req_t wb_in;
        dadda_mul_pkg::wb_rsp_t wb_out;
        int                     errors;
        int                     checks;
        int                     accesses;
        int                     acks_seen;
        int                     cycles;

        dadda_mul_top u_dut (
                .clk    (clk),
                .rst_n  (rst_n),
                .wb_in  (wb_in),
                .wb_out (wb_out)
        );

        `include "wb_master_tasks.svh"

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk) begin
                cycles++;
                if (wb_out.ack)
                        acks_seen++;
                if (cycles >= CYCLE_LIMIT) begin
                        $display("timeout, tests still running after %0d cycles", CYCLE_LIMIT);
                        $display("sim failed");
                        $finish;
                end
        end

        task automatic wait_done();
                logic [`WB_DAT_WIDTH-1:0] st;
                int polls;
                st    = '0;
                polls = 0;
                while (!st[`STATUS_DONE_BIT] && polls < 20) begin
                        wb_read(dadda_mul_pkg::REG_STATUS, st);
                        polls++;
                end
                if (!st[`STATUS_DONE_BIT]) begin
                        errors++;
                        $display("done never came up after a start");
                end
        endtask

        task automatic multiply_check(input dadda_mul_pkg::operand_t a,
                                      input dadda_mul_pkg::operand_t b,
                                      output dadda_mul_pkg::product_t res);
                dadda_mul_pkg::product_t exp;
                exp = {16'h0, a} * {16'h0, b};
                wb_write(dadda_mul_pkg::REG_A, {16'h0, a});
                wb_write(dadda_mul_pkg::REG_B, {16'h0, b});
                wb_write(dadda_mul_pkg::REG_CTRL, START);
                wait_done();
                wb_read(dadda_mul_pkg::REG_RESULT, res);
                check_product("result", res, exp);
        endtask

        task automatic test_reset_values();
                logic [`WB_DAT_WIDTH-1:0] rd;
                wb_read(dadda_mul_pkg::REG_STATUS, rd);
                check_data("status", rd, '0);
                wb_read(dadda_mul_pkg::REG_RESULT, rd);
                check_data("result", rd, '0);
                wb_read(dadda_mul_pkg::REG_A, rd);
                check_data("a", rd, '0);
                wb_read(dadda_mul_pkg::REG_B, rd);
                check_data("b", rd, '0);
        endtask

        task automatic test_corners();
                dadda_mul_pkg::product_t res;
                multiply_check(16'h0000, 16'h1234, res);
                multiply_check(16'h5a5a, 16'h0000, res);
                multiply_check(16'h0001, 16'hbeef, res);
                multiply_check(16'hc0de, 16'h0001, res);
                multiply_check(16'hffff, 16'hffff, res);
                check_product("ffff squared", res, 32'hfffe0001);
                multiply_check(16'h8000, 16'h8000, res);
                check_product("8000 squared", res, 32'h40000000);
        endtask

        task automatic test_busy_done();
                logic [`WB_DAT_WIDTH-1:0] rd;
                wb_write(dadda_mul_pkg::REG_A, 32'h0000_abcd);
                wb_write(dadda_mul_pkg::REG_B, 32'h0000_0123);
                wb_write(dadda_mul_pkg::REG_CTRL, START);
                wb_read(dadda_mul_pkg::REG_STATUS, rd);
                check_status(rd, 1'b1, 1'b0);
                // second poll lands four cycles after the start ack
                wb_read(dadda_mul_pkg::REG_STATUS, rd);
                check_status(rd, 1'b0, 1'b1);
                wb_read(dadda_mul_pkg::REG_RESULT, rd);
                check_product("result", rd, 32'h00c3_4a07);
                wb_write(dadda_mul_pkg::REG_CTRL, START);
                wb_read(dadda_mul_pkg::REG_STATUS, rd);
                check_status(rd, 1'b1, 1'b0);
                wait_done();
        endtask

        task automatic test_start_while_busy();
                logic [`WB_DAT_WIDTH-1:0] rd;
                wb_write(dadda_mul_pkg::REG_A, 32'h0000_1357);
                wb_write(dadda_mul_pkg::REG_B, 32'h0000_2468);
                wb_write(dadda_mul_pkg::REG_CTRL, START);
                wb_write(dadda_mul_pkg::REG_CTRL, START);
                // an accepted second start would still show busy here
                wb_read(dadda_mul_pkg::REG_STATUS, rd);
                check_status(rd, 1'b0, 1'b1);
                wb_write(dadda_mul_pkg::REG_A, 32'h0000_7777);
                wb_read(dadda_mul_pkg::REG_RESULT, rd);
                check_product("result", rd, 32'h02c0_1758);
        endtask

        task automatic test_random();
                dadda_mul_pkg::operand_t a;
                dadda_mul_pkg::operand_t b;
                dadda_mul_pkg::product_t res;
                logic [`WB_DAT_WIDTH-1:0] rd;
                for (int n = 0; n < 100; n++) begin
                        a = dadda_mul_pkg::operand_t'($urandom);
                        b = dadda_mul_pkg::operand_t'($urandom);
                        multiply_check(a, b, res);
                        wb_read(dadda_mul_pkg::REG_A, rd);
                        check_data("a", rd, {16'h0, a});
                        wb_read(dadda_mul_pkg::REG_B, rd);
                        check_data("b", rd, {16'h0, b});
                end
        endtask

        task automatic test_unmapped();
                logic [`WB_DAT_WIDTH-1:0] a_old;
                logic [`WB_DAT_WIDTH-1:0] b_old;
                logic [`WB_DAT_WIDTH-1:0] res_old;
                logic [`WB_DAT_WIDTH-1:0] rd;
                wb_read(dadda_mul_pkg::REG_A, a_old);
                wb_read(dadda_mul_pkg::REG_B, b_old);
                wb_read(dadda_mul_pkg::REG_RESULT, res_old);
                for (int adr = 5; adr < 8; adr++) begin
                        wb_write(adr[`WB_ADR_WIDTH-1:0], 32'hffff_ffff);
                        wb_read(adr[`WB_ADR_WIDTH-1:0], rd);
                        check_data("unmapped", rd, '0);
                end
                // every bit but start set, so a stored ctrl would read back nonzero
                wb_write(dadda_mul_pkg::REG_CTRL, ~START);
                wb_read(dadda_mul_pkg::REG_CTRL, rd);
                check_data("ctrl", rd, '0);
                wb_read(dadda_mul_pkg::REG_A, rd);
                check_data("a", rd, a_old);
                wb_read(dadda_mul_pkg::REG_B, rd);
                check_data("b", rd, b_old);
                wb_read(dadda_mul_pkg::REG_RESULT, rd);
                check_data("result", rd, res_old);
        endtask

        initial begin : main
                errors    = 0;
                checks    = 0;
                accesses  = 0;
                acks_seen = 0;
                cycles    = 0;
                wb_in     = '0;
                rst_n     = 1'b0;
                void'($urandom(8073));
                repeat (8) @(posedge clk);
                #1 rst_n = 1'b1;
                @(posedge clk);
                #1;
                test_reset_values();
                test_corners();
                test_busy_done();
                test_start_while_busy();
                test_random();
                test_unmapped();
                repeat (2) @(posedge clk);
                check_data("ack count", acks_seen, accesses);
                $display("checks %0d errors %0d", checks, errors);
                if (errors == 0)
                        $display("sim passed");
                else
                        $display("sim failed");
                $finish;
        end

endmodule

/* dadda_mul.f */
+incdir+design
+incdir+tb
design/dadda_mul_pkg.sv
design/wb_mul_ctrl.sv
design/dadda_tree.sv
design/cp_adder.sv
design/dadda_mul_top.sv
tb/dadda_mul_tb.sv
